/* design/cache_pkg.sv */
/*
 * Shared types for the data cache: request kinds, cache memory states
 * and the control register map. Referenced by scoped name only.
 */
package cache_pkg;

   // Request kind, a write is any request with a strobe bit set
   typedef enum logic {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } op_e;

   // Cache memory FSM states
   typedef enum logic [1:0] {
      ST_IDLE   = 2'd0,
      ST_LOOKUP = 2'd1,
      ST_FILL   = 2'd2,
      ST_WRITE  = 2'd3
   } mem_state_e;

   // Control register index width
   localparam int CSR_ADDR_W = 2;

   // Control register map, indexed by word address
   typedef enum logic [CSR_ADDR_W-1:0] {
      CSR_HITS       = 2'd0,
      CSR_MISSES     = 2'd1,
      CSR_INVALIDATE = 2'd2
   } csr_e;

endpackage

/* design/cache_front_end.sv */
/*
 * Processor side of the cache. Splits each request between the cache
 * memory and the control registers and returns read data in order.
 */
module cache_front_end #(
   parameter int ADDR_W = 16,
   parameter int DATA_W = 32
) (
   input  logic                             clk_i,
   input  logic                             reset_i,
   input  logic                             iob_valid_i,
   input  logic [ADDR_W-1:0]                iob_addr_i,
   input  logic [DATA_W-1:0]                iob_wdata_i,
   input  logic [DATA_W/8-1:0]              iob_wstrb_i,
   output logic                             iob_ready_o,
   output logic                             iob_rvalid_o,
   output logic [DATA_W-1:0]                iob_rdata_o,
   output logic                             data_req_o,
   output logic [ADDR_W-2:0]                data_addr_o,
   input  logic [DATA_W-1:0]                data_rdata_i,
   input  logic                             data_ack_i,
   output logic                             data_req_reg_o,
   output logic [ADDR_W-2:0]                data_addr_reg_o,
   output logic [DATA_W-1:0]                data_wdata_reg_o,
   output logic [DATA_W/8-1:0]              data_wstrb_reg_o,
   output logic                             ctrl_req_o,
   output logic [cache_pkg::CSR_ADDR_W-1:0] ctrl_addr_o,
   output logic [DATA_W-1:0]                ctrl_wdata_o,
   output logic                             ctrl_we_o,
   input  logic [DATA_W-1:0]                ctrl_rdata_i,
   input  logic                             ctrl_ack_i
);

   localparam int OFF_W = $clog2(DATA_W / 8);

   logic           ack;
   logic           accept;
   logic           ctrl_sel;
   logic           ctrl_pend_q;
   cache_pkg::op_e op_q;

   // Either side ends the pending request
   assign ack         = data_ack_i | ctrl_ack_i;
   assign iob_ready_o = ~(data_req_reg_o | ctrl_pend_q) | ack;
   assign accept      = iob_valid_i & iob_ready_o;

   // Top address bit selects the control registers
   assign ctrl_sel    = iob_addr_i[ADDR_W-1];

   assign data_req_o  = accept & ~ctrl_sel;
   assign data_addr_o = iob_addr_i[ADDR_W-2:0];

   // Register index comes from the word address
   assign ctrl_req_o   = accept & ctrl_sel;
   assign ctrl_addr_o  = iob_addr_i[OFF_W +: cache_pkg::CSR_ADDR_W];
   assign ctrl_wdata_o = iob_wdata_i;
   assign ctrl_we_o    = |iob_wstrb_i;

   // Read data from whichever side answered, writes return nothing
   assign iob_rdata_o  = ctrl_ack_i ? ctrl_rdata_i : data_rdata_i;
   assign iob_rvalid_o = ack & (op_q == cache_pkg::OP_READ);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         data_req_reg_o <= 1'b0;
         ctrl_pend_q    <= 1'b0;
         op_q           <= cache_pkg::OP_READ;
      end else begin
         if (data_req_o | data_ack_i) begin
            data_req_reg_o <= data_req_o;
         end
         if (ctrl_req_o | ctrl_ack_i) begin
            ctrl_pend_q <= ctrl_req_o;
         end
         if (accept) begin
            op_q <= (|iob_wstrb_i) ? cache_pkg::OP_WRITE : cache_pkg::OP_READ;
         end
      end
   end

   // Payload of the accepted data request
   always_ff @(posedge clk_i) begin
      if (data_req_o) begin
         data_addr_reg_o  <= iob_addr_i[ADDR_W-2:0];
         data_wdata_reg_o <= iob_wdata_i;
         data_wstrb_reg_o <= iob_wstrb_i;
      end
   end

endmodule

/* design/cache_memory.sv */
/*
 * Direct-mapped, write-through cache storage with one word per line.
 * Looks up registered requests, fills read misses and forwards writes.
 */
module cache_memory #(
   parameter int ADDR_W  = 16,
   parameter int DATA_W  = 32,
   parameter int INDEX_W = 4
) (
   input  logic                clk_i,
   input  logic                reset_i,
   input  logic                data_req_i,
   input  logic [ADDR_W-2:0]   data_addr_i,
   input  logic                data_req_reg_i,
   input  logic [ADDR_W-2:0]   data_addr_reg_i,
   input  logic [DATA_W-1:0]   data_wdata_reg_i,
   input  logic [DATA_W/8-1:0] data_wstrb_reg_i,
   output logic                data_ack_o,
   output logic [DATA_W-1:0]   data_rdata_o,
   input  logic                invalidate_i,
   output logic                lookup_hit_o,
   output logic                lookup_miss_o,
   output logic                fill_req_o,
   output logic [ADDR_W-2:0]   fill_addr_o,
   output logic                fill_we_o,
   output logic [DATA_W-1:0]   fill_wdata_o,
   output logic [DATA_W/8-1:0] fill_wstrb_o,
   input  logic                fill_done_i,
   input  logic [DATA_W-1:0]   fill_rdata_i
);

   localparam int OFF_W = $clog2(DATA_W / 8);
   localparam int TAG_W = ADDR_W - 1 - OFF_W - INDEX_W;
   localparam int LINES = 2 ** INDEX_W;

   cache_pkg::mem_state_e state_q;
   cache_pkg::mem_state_e state_d;

   logic [TAG_W-1:0]   tag_mem  [LINES];
   logic [DATA_W-1:0]  data_mem [LINES];
   logic [LINES-1:0]   valid_q;

   logic [TAG_W-1:0]   rd_tag_q;
   logic [DATA_W-1:0]  rd_data_q;
   logic [INDEX_W-1:0] rd_idx;
   logic [INDEX_W-1:0] reg_idx;
   logic [TAG_W-1:0]   reg_tag;
   logic               is_write;
   logic               hit;
   logic               arr_we;
   logic [DATA_W-1:0]  arr_wdata;
   logic [DATA_W-1:0]  merged;

   assign rd_idx   = data_addr_i[OFF_W +: INDEX_W];
   assign reg_idx  = data_addr_reg_i[OFF_W +: INDEX_W];
   assign reg_tag  = data_addr_reg_i[ADDR_W-2 -: TAG_W];
   assign is_write = |data_wstrb_reg_i;
   assign hit      = valid_q[reg_idx] & (rd_tag_q == reg_tag);

   // Byte merge of a write hit into the stored word
   always_comb begin
      for (int b = 0; b < DATA_W / 8; b++) begin
         merged[8*b +: 8] = data_wstrb_reg_i[b] ? data_wdata_reg_i[8*b +: 8]
                                                : rd_data_q[8*b +: 8];
      end
   end

   always_comb begin
      state_d       = state_q;
      data_ack_o    = 1'b0;
      lookup_hit_o  = 1'b0;
      lookup_miss_o = 1'b0;
      arr_we        = 1'b0;
      arr_wdata     = merged;
      case (state_q)
         cache_pkg::ST_IDLE: begin
            if (data_req_i) begin
               state_d = cache_pkg::ST_LOOKUP;
            end
         end
         cache_pkg::ST_LOOKUP: begin
            if (data_req_reg_i) begin
               if (is_write) begin
                  // No write-allocate, only a hit updates the line
                  arr_we  = hit;
                  state_d = cache_pkg::ST_WRITE;
               end else if (hit) begin
                  lookup_hit_o = 1'b1;
                  data_ack_o   = 1'b1;
               end else begin
                  lookup_miss_o = 1'b1;
                  state_d       = cache_pkg::ST_FILL;
               end
            end
         end
         cache_pkg::ST_FILL: begin
            if (fill_done_i) begin
               arr_we     = 1'b1;
               arr_wdata  = fill_rdata_i;
               data_ack_o = 1'b1;
            end
         end
         default: begin
            data_ack_o = fill_done_i;
         end
      endcase
      // A new request may be accepted in the ack cycle
      if (data_ack_o) begin
         state_d = data_req_i ? cache_pkg::ST_LOOKUP : cache_pkg::ST_IDLE;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= cache_pkg::ST_IDLE;
         valid_q <= '0;
      end else begin
         state_q <= state_d;
         if (invalidate_i) begin
            valid_q <= '0;
         end else if (state_q == cache_pkg::ST_FILL && fill_done_i) begin
            valid_q[reg_idx] <= 1'b1;
         end
      end
   end

   // Arrays, read on acceptance with the line being written forwarded
   always_ff @(posedge clk_i) begin
      if (arr_we) begin
         tag_mem[reg_idx]  <= reg_tag;
         data_mem[reg_idx] <= arr_wdata;
      end
      if (data_req_i) begin
         if (arr_we && reg_idx == rd_idx) begin
            rd_tag_q  <= reg_tag;
            rd_data_q <= arr_wdata;
         end else begin
            rd_tag_q  <= tag_mem[rd_idx];
            rd_data_q <= data_mem[rd_idx];
         end
      end
   end

   assign data_rdata_o = (state_q == cache_pkg::ST_FILL) ? fill_rdata_i : rd_data_q;

   // Backing requests are word aligned
   assign fill_req_o   = (state_q == cache_pkg::ST_FILL) | (state_q == cache_pkg::ST_WRITE);
   assign fill_we_o    = (state_q == cache_pkg::ST_WRITE);
   assign fill_addr_o  = {data_addr_reg_i[ADDR_W-2:OFF_W], {OFF_W{1'b0}}};
   assign fill_wdata_o = data_wdata_reg_i;
   assign fill_wstrb_o = data_wstrb_reg_i;

endmodule

/* design/cache_back_end.sv */
/*
 * Backing memory side. Turns each fill request into one bus transaction
 * and reports completion with a single done pulse.
 */
module cache_back_end #(
   parameter int ADDR_W = 16,
   parameter int DATA_W = 32
) (
   input  logic                clk_i,
   input  logic                reset_i,
   input  logic                fill_req_i,
   input  logic [ADDR_W-2:0]   fill_addr_i,
   input  logic                fill_we_i,
   input  logic [DATA_W-1:0]   fill_wdata_i,
   input  logic [DATA_W/8-1:0] fill_wstrb_i,
   output logic                fill_done_o,
   output logic [DATA_W-1:0]   fill_rdata_o,
   output logic                be_valid_o,
   output logic [ADDR_W-2:0]   be_addr_o,
   output logic                be_we_o,
   output logic [DATA_W-1:0]   be_wdata_o,
   output logic [DATA_W/8-1:0] be_wstrb_o,
   input  logic                be_ready_i,
   input  logic                be_rvalid_i,
   input  logic [DATA_W-1:0]   be_rdata_i
);

   logic active_q;
   logic wait_q;
   logic launch;

   // One transaction per request, held until done
   assign launch = fill_req_i & ~active_q;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         active_q    <= 1'b0;
         wait_q      <= 1'b0;
         be_valid_o  <= 1'b0;
         fill_done_o <= 1'b0;
      end else begin
         fill_done_o <= 1'b0;
         if (launch) begin
            active_q   <= 1'b1;
            be_valid_o <= 1'b1;
         end else if (fill_done_o) begin
            active_q <= 1'b0;
         end
         if (be_valid_o && be_ready_i) begin
            be_valid_o <= 1'b0;
            if (be_we_o) begin
               fill_done_o <= 1'b1;
            end else begin
               wait_q <= 1'b1;
            end
         end
         // Read data closes a read transaction
         if (wait_q && be_rvalid_i) begin
            wait_q      <= 1'b0;
            fill_done_o <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (launch) begin
         be_addr_o  <= fill_addr_i;
         be_we_o    <= fill_we_i;
         be_wdata_o <= fill_wdata_i;
         be_wstrb_o <= fill_wstrb_i;
      end
      if (wait_q && be_rvalid_i) begin
         fill_rdata_o <= be_rdata_i;
      end
   end

endmodule

/* design/cache_ctrl.sv */
/*
 * Control registers: hit and miss counters and the invalidate command.
 * Every request is answered one cycle later.
 */
module cache_ctrl #(
   parameter int DATA_W = 32
) (
   input  logic                             clk_i,
   input  logic                             reset_i,
   input  logic                             ctrl_req_i,
   input  logic [cache_pkg::CSR_ADDR_W-1:0] ctrl_addr_i,
   input  logic [DATA_W-1:0]                ctrl_wdata_i,
   input  logic                             ctrl_we_i,
   output logic                             ctrl_ack_o,
   output logic [DATA_W-1:0]                ctrl_rdata_o,
   input  logic                             lookup_hit_i,
   input  logic                             lookup_miss_i,
   output logic                             invalidate_o
);

   cache_pkg::csr_e   csr;
   logic              inv_cmd;
   logic [DATA_W-1:0] hits_q;
   logic [DATA_W-1:0] misses_q;

   assign csr = cache_pkg::csr_e'(ctrl_addr_i);

   // Any write to the command register invalidates
   assign inv_cmd = ctrl_req_i & ctrl_we_i & (csr == cache_pkg::CSR_INVALIDATE);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         ctrl_ack_o   <= 1'b0;
         invalidate_o <= 1'b0;
         hits_q       <= '0;
         misses_q     <= '0;
      end else begin
         ctrl_ack_o   <= ctrl_req_i;
         invalidate_o <= inv_cmd;
         if (inv_cmd) begin
            hits_q   <= '0;
            misses_q <= '0;
         end else begin
            // Counters saturate
            if (lookup_hit_i && hits_q != '1) begin
               hits_q <= hits_q + 1'b1;
            end
            if (lookup_miss_i && misses_q != '1) begin
               misses_q <= misses_q + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (ctrl_req_i) begin
         case (csr)
            cache_pkg::CSR_HITS:   ctrl_rdata_o <= hits_q;
            cache_pkg::CSR_MISSES: ctrl_rdata_o <= misses_q;
            default:               ctrl_rdata_o <= '0;
         endcase
      end
   end

endmodule

/* design/cache_top.sv */
/*
 * Data cache top level. Connects front end, cache memory, back end and
 * control registers, and sets the shared parameters.
 */
module cache_top #(
   parameter int ADDR_W  = 16,
   parameter int DATA_W  = 32,
   parameter int INDEX_W = 4
) (
   input  logic                clk_i,
   input  logic                reset_i,
   input  logic                iob_valid_i,
   input  logic [ADDR_W-1:0]   iob_addr_i,
   input  logic [DATA_W-1:0]   iob_wdata_i,
   input  logic [DATA_W/8-1:0] iob_wstrb_i,
   output logic                iob_ready_o,
   output logic                iob_rvalid_o,
   output logic [DATA_W-1:0]   iob_rdata_o,
   output logic                be_valid_o,
   output logic [ADDR_W-2:0]   be_addr_o,
   output logic                be_we_o,
   output logic [DATA_W-1:0]   be_wdata_o,
   output logic [DATA_W/8-1:0] be_wstrb_o,
   input  logic                be_ready_i,
   input  logic                be_rvalid_i,
   input  logic [DATA_W-1:0]   be_rdata_i
);

   // Front end to cache memory
   logic                             data_req;
   logic [ADDR_W-2:0]                data_addr;
   logic                             data_req_reg;
   logic [ADDR_W-2:0]                data_addr_reg;
   logic [DATA_W-1:0]                data_wdata_reg;
   logic [DATA_W/8-1:0]              data_wstrb_reg;
   logic                             data_ack;
   logic [DATA_W-1:0]                data_rdata;

   // Front end to control registers
   logic                             ctrl_req;
   logic [cache_pkg::CSR_ADDR_W-1:0] ctrl_addr;
   logic [DATA_W-1:0]                ctrl_wdata;
   logic                             ctrl_we;
   logic                             ctrl_ack;
   logic [DATA_W-1:0]                ctrl_rdata;

   logic                             lookup_hit;
   logic                             lookup_miss;
   logic                             invalidate;

   // Cache memory to back end
   logic                             fill_req;
   logic [ADDR_W-2:0]                fill_addr;
   logic                             fill_we;
   logic [DATA_W-1:0]                fill_wdata;
   logic [DATA_W/8-1:0]              fill_wstrb;
   logic                             fill_done;
   logic [DATA_W-1:0]                fill_rdata;

   cache_front_end #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W)
   ) front_end_i (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .iob_valid_i     (iob_valid_i),
      .iob_addr_i      (iob_addr_i),
      .iob_wdata_i     (iob_wdata_i),
      .iob_wstrb_i     (iob_wstrb_i),
      .iob_ready_o     (iob_ready_o),
      .iob_rvalid_o    (iob_rvalid_o),
      .iob_rdata_o     (iob_rdata_o),
      .data_req_o      (data_req),
      .data_addr_o     (data_addr),
      .data_rdata_i    (data_rdata),
      .data_ack_i      (data_ack),
      .data_req_reg_o  (data_req_reg),
      .data_addr_reg_o (data_addr_reg),
      .data_wdata_reg_o(data_wdata_reg),
      .data_wstrb_reg_o(data_wstrb_reg),
      .ctrl_req_o      (ctrl_req),
      .ctrl_addr_o     (ctrl_addr),
      .ctrl_wdata_o    (ctrl_wdata),
      .ctrl_we_o       (ctrl_we),
      .ctrl_rdata_i    (ctrl_rdata),
      .ctrl_ack_i      (ctrl_ack)
   );

   cache_memory #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W),
      .INDEX_W(INDEX_W)
   ) memory_i (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .data_req_i      (data_req),
      .data_addr_i     (data_addr),
      .data_req_reg_i  (data_req_reg),
      .data_addr_reg_i (data_addr_reg),
      .data_wdata_reg_i(data_wdata_reg),
      .data_wstrb_reg_i(data_wstrb_reg),
      .data_ack_o      (data_ack),
      .data_rdata_o    (data_rdata),
      .invalidate_i    (invalidate),
      .lookup_hit_o    (lookup_hit),
      .lookup_miss_o   (lookup_miss),
      .fill_req_o      (fill_req),
      .fill_addr_o     (fill_addr),
      .fill_we_o       (fill_we),
      .fill_wdata_o    (fill_wdata),
      .fill_wstrb_o    (fill_wstrb),
      .fill_done_i     (fill_done),
      .fill_rdata_i    (fill_rdata)
   );

   cache_back_end #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W)
   ) back_end_i (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .fill_req_i  (fill_req),
      .fill_addr_i (fill_addr),
      .fill_we_i   (fill_we),
      .fill_wdata_i(fill_wdata),
      .fill_wstrb_i(fill_wstrb),
      .fill_done_o (fill_done),
      .fill_rdata_o(fill_rdata),
      .be_valid_o  (be_valid_o),
      .be_addr_o   (be_addr_o),
      .be_we_o     (be_we_o),
      .be_wdata_o  (be_wdata_o),
      .be_wstrb_o  (be_wstrb_o),
      .be_ready_i  (be_ready_i),
      .be_rvalid_i (be_rvalid_i),
      .be_rdata_i  (be_rdata_i)
   );

   cache_ctrl #(
      .DATA_W(DATA_W)
   ) ctrl_i (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .ctrl_req_i   (ctrl_req),
      .ctrl_addr_i  (ctrl_addr),
      .ctrl_wdata_i (ctrl_wdata),
      .ctrl_we_i    (ctrl_we),
      .ctrl_ack_o   (ctrl_ack),
      .ctrl_rdata_o (ctrl_rdata),
      .lookup_hit_i (lookup_hit),
      .lookup_miss_i(lookup_miss),
      .invalidate_o (invalidate)
   );

endmodule

/* bench/mem_model.sv */
/*
 * Backing memory for the cache testbench. Answers each backing bus
 * transaction after a random ready delay and a random read data delay.
 */
module mem_model #(
   parameter int ADDR_W = 16,
   parameter int DATA_W = 32
) (
   input  logic                clk_i,
   input  logic                be_valid_i,
   input  logic [ADDR_W-2:0]   be_addr_i,
   input  logic                be_we_i,
   input  logic [DATA_W-1:0]   be_wdata_i,
   input  logic [DATA_W/8-1:0] be_wstrb_i,
   output logic                be_ready_o,
   output logic                be_rvalid_o,
   output logic [DATA_W-1:0]   be_rdata_o
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int OFF_W  = $clog2(DATA_W / 8);
   localparam int WORD_W = ADDR_W - 1 - OFF_W;
   localparam int WORDS  = 2 ** WORD_W;

   logic [DATA_W-1:0] mem [WORDS];

   // Contents depend on every bit of the word address
   function automatic logic [DATA_W-1:0] initial_word(input logic [WORD_W-1:0] w);
      return {w ^ WORD_W'('h0A5C), 6'h2D, ~w};
   endfunction

   initial begin : serve
      logic [WORD_W-1:0]   word;
      logic                we;
      logic [DATA_W-1:0]   wdata;
      logic [DATA_W/8-1:0] wstrb;
      be_ready_o  = 1'b0;
      be_rvalid_o = 1'b0;
      be_rdata_o  = '0;
      for (int i = 0; i < WORDS; i++) begin
         mem[i] = initial_word(WORD_W'(i));
      end
      forever begin
         @(posedge clk_i);
         #1;
         if (be_valid_i) begin
            repeat ($urandom_range(3, 0)) begin
               @(posedge clk_i);
               #1;
            end
            // Request is held steady until the handshake
            word       = be_addr_i[ADDR_W-2:OFF_W];
            we         = be_we_i;
            wdata      = be_wdata_i;
            wstrb      = be_wstrb_i;
            be_ready_o = 1'b1;
            @(posedge clk_i);
            #1;
            be_ready_o = 1'b0;
            if (we) begin
               for (int b = 0; b < DATA_W / 8; b++) begin
                  if (wstrb[b]) begin
                     mem[word][8*b +: 8] = wdata[8*b +: 8];
                  end
               end
            end else begin
               repeat ($urandom_range(3, 0)) begin
                  @(posedge clk_i);
                  #1;
               end
               be_rdata_o  = mem[word];
               be_rvalid_o = 1'b1;
               @(posedge clk_i);
               #1;
               be_rvalid_o = 1'b0;
            end
         end
      end
   end

endmodule

/* bench/cache_tb.sv */
/*
 * Testbench for the data cache. Issues random processor requests and checks
 * read data, latency, backing writes and counters against a reference model.
 */
module cache_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int ADDR_W     = 16;
   localparam int DATA_W     = 32;
   localparam int INDEX_W    = 4;
   localparam int OFF_W      = $clog2(DATA_W / 8);
   localparam int WORD_W     = ADDR_W - 1 - OFF_W;
   localparam int TAG_W      = WORD_W - INDEX_W;
   localparam int WORDS      = 2 ** WORD_W;
   localparam int LINES      = 2 ** INDEX_W;
   localparam int CLK_PERIOD = 4;
   localparam int NUM_RANDOM = 400;
   // Upper bound on requests issued over all tests
   localparam int NUM_REQS   = NUM_RANDOM + 40;

   logic                clk_i = 1'b0;
   logic                reset_i;
   logic                iob_valid_i;
   logic [ADDR_W-1:0]   iob_addr_i;
   logic [DATA_W-1:0]   iob_wdata_i;
   logic [DATA_W/8-1:0] iob_wstrb_i;
   logic                iob_ready_o;
   logic                iob_rvalid_o;
   logic [DATA_W-1:0]   iob_rdata_o;
   logic                be_valid_o;
   logic [ADDR_W-2:0]   be_addr_o;
   logic                be_we_o;
   logic [DATA_W-1:0]   be_wdata_o;
   logic [DATA_W/8-1:0] be_wstrb_o;
   logic                be_ready_i;
   logic                be_rvalid_i;
   logic [DATA_W-1:0]   be_rdata_i;

   // Reference model of memory, tag mirror and counters
   logic [DATA_W-1:0]   model_mem [WORDS];
   logic [TAG_W-1:0]    mirror_tag [LINES];
   logic [LINES-1:0]    mirror_valid = '0;
   int                  model_hits = 0;
   int                  model_misses = 0;
   int                  cycle = 0;

   // Outstanding reads in order, cycle is -1 when latency is not fixed
   logic [DATA_W-1:0]   rd_data_q [$];
   int                  rd_cycle_q [$];
   string               rd_name_q [$];
   logic [ADDR_W-2:0]   wr_addr_q [$];
   logic [DATA_W-1:0]   wr_data_q [$];
   logic [DATA_W/8-1:0] wr_strb_q [$];

   cache_top #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .INDEX_W(INDEX_W)) dut_i (.*);

   mem_model #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) mem_i (
      .clk_i(clk_i), .be_valid_i(be_valid_o), .be_addr_i(be_addr_o), .be_we_i(be_we_o),
      .be_wdata_i(be_wdata_o), .be_wstrb_i(be_wstrb_o), .be_ready_o(be_ready_i),
      .be_rvalid_o(be_rvalid_i), .be_rdata_o(be_rdata_i)
   );

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycle++;
   end

   task automatic stop_with_failure(input string reason);
      $display("%s", reason);
      $display("Simulation FAILED");
      $fatal(1, "stopped at the first failure");
   endtask

   task automatic compare(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
      if (expected !== actual) begin
         stop_with_failure($sformatf("[ERROR] %s: expected %0h, actual %0h",
                                     name, expected, actual));
      end
   endtask

   function automatic logic [DATA_W-1:0] initial_word(input logic [WORD_W-1:0] w);
      return {w ^ WORD_W'('h0A5C), 6'h2D, ~w};
   endfunction

   function automatic logic [ADDR_W-1:0] csr_address(
      input logic [cache_pkg::CSR_ADDR_W-1:0] idx);
      return {1'b1, {(WORD_W - cache_pkg::CSR_ADDR_W){1'b0}}, idx, {OFF_W{1'b0}}};
   endfunction

   // Starts and ends 1 ns after a rising edge
   task automatic drive_request(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                                input logic [DATA_W/8-1:0] wstrb, output int acc);
      iob_valid_i = 1'b1;
      iob_addr_i  = addr;
      iob_wdata_i = wdata;
      iob_wstrb_i = wstrb;
      @(negedge clk_i);
      while (!iob_ready_o) begin
         @(negedge clk_i);
      end
      acc = cycle;
      @(posedge clk_i);
      #1;
      iob_valid_i = 1'b0;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk_i);
         #1;
      end
   endtask

   task automatic data_access(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                              input logic [DATA_W/8-1:0] wstrb, output int acc);
      logic [WORD_W-1:0]  word;
      logic [INDEX_W-1:0] idx;
      logic [TAG_W-1:0]   tag;
      bit                 hit;
      word = addr[ADDR_W-2:OFF_W];
      idx  = addr[OFF_W +: INDEX_W];
      tag  = addr[ADDR_W-2 -: TAG_W];
      hit  = mirror_valid[idx] && mirror_tag[idx] == tag;
      drive_request(addr, wdata, wstrb, acc);
      if (wstrb == '0) begin
         if (hit) begin
            model_hits++;
         end else begin
            model_misses++;
            mirror_valid[idx] = 1'b1;
            mirror_tag[idx]   = tag;
         end
         rd_data_q.push_back(model_mem[word]);
         rd_cycle_q.push_back(hit ? acc : -1);
         rd_name_q.push_back($sformatf("read %0h", addr));
      end else begin
         // Write-through without allocation, mirror unchanged
         for (int b = 0; b < DATA_W / 8; b++) begin
            if (wstrb[b]) begin
               model_mem[word][8*b +: 8] = wdata[8*b +: 8];
            end
         end
         wr_addr_q.push_back({word, {OFF_W{1'b0}}});
         wr_data_q.push_back(wdata);
         wr_strb_q.push_back(wstrb);
      end
   endtask

   task automatic csr_read(input logic [cache_pkg::CSR_ADDR_W-1:0] idx,
                           input logic [DATA_W-1:0] expected, input string name);
      int acc;
      drive_request(csr_address(idx), '0, '0, acc);
      rd_data_q.push_back(expected);
      rd_cycle_q.push_back(acc);
      rd_name_q.push_back(name);
   endtask

   task automatic invalidate_cache();
      int acc;
      drive_request(csr_address(cache_pkg::CSR_INVALIDATE), $urandom, '1, acc);
      mirror_valid = '0;
      model_hits   = 0;
      model_misses = 0;
   endtask

   // Waits until every request has completed
   task automatic drain();
      @(negedge clk_i);
      while (rd_data_q.size() != 0 || wr_addr_q.size() != 0 || !iob_ready_o) begin
         @(negedge clk_i);
      end
      @(posedge clk_i);
      #1;
   endtask

   always @(negedge clk_i) begin
      if (iob_rvalid_o) begin
         if (rd_data_q.size() == 0) begin
            stop_with_failure("Read data returned while no read was outstanding");
         end else begin
            compare(rd_name_q[0], rd_data_q[0], iob_rdata_o);
            if (rd_cycle_q[0] >= 0) begin
               compare({rd_name_q[0], " latency"}, rd_cycle_q[0] + 1, cycle);
            end
            void'(rd_data_q.pop_front());
            void'(rd_cycle_q.pop_front());
            void'(rd_name_q.pop_front());
         end
      end
      // Handshake completes at the next rising edge
      if (be_valid_o && be_ready_i && be_we_o) begin
         if (wr_addr_q.size() == 0) begin
            stop_with_failure("Backing bus write seen while no write was expected");
         end else begin
            compare("backing write address", wr_addr_q.pop_front(), be_addr_o);
            compare("backing write data", wr_data_q.pop_front(), be_wdata_o);
            compare("backing write strobes", wr_strb_q.pop_front(), be_wstrb_o);
         end
      end
   end

   // Generous bound of 200 cycles per request
   initial begin : watchdog
      #(NUM_REQS * 200 * CLK_PERIOD);
      stop_with_failure("Timeout, the requests did not complete in the allowed time");
   end

   initial begin : main
      logic [ADDR_W-1:0]   cached [$];
      logic [5:0]          word;
      logic [DATA_W/8-1:0] strb;
      int                  acc;
      int                  prev;
      void'($urandom(23963));
      for (int i = 0; i < WORDS; i++) begin
         model_mem[i] = initial_word(WORD_W'(i));
      end
      reset_i     = 1'b1;
      iob_valid_i = 1'b0;
      iob_addr_i  = '0;
      iob_wdata_i = '0;
      iob_wstrb_i = '0;
      repeat (2) @(posedge clk_i);
      #1;
      reset_i = 1'b0;

      compare("ready after reset", 1, iob_ready_o);
      compare("rvalid after reset", 0, iob_rvalid_o);
      compare("backing valid after reset", 0, be_valid_o);
      csr_read(cache_pkg::CSR_HITS, 0, "hit counter after reset");
      csr_read(cache_pkg::CSR_MISSES, 0, "miss counter after reset");

      // Fill four lines, then read them back to back
      for (int i = 0; i < 4; i++) begin
         data_access(ADDR_W'(i) << OFF_W, '0, '0, acc);
      end
      idle_cycles(2);
      for (int i = 0; i < 4; i++) begin
         data_access(ADDR_W'(i) << OFF_W, '0, '0, acc);
         if (i > 0) begin
            compare("back-to-back hit accept cycle", prev + 1, acc);
         end
         prev = acc;
      end

      // 64 words over 16 lines so that tags conflict
      for (int n = 0; n < NUM_RANDOM; n++) begin
         word = 6'($urandom_range(63, 0));
         strb = '0;
         if ($urandom_range(1, 0) == 1) begin
            strb = 4'($urandom_range(15, 1));
         end
         data_access({8'h00, word, {OFF_W{1'b0}}}, $urandom, strb, acc);
         idle_cycles($urandom_range(2, 0));
      end
      drain();
      idle_cycles(1);
      csr_read(cache_pkg::CSR_HITS, model_hits, "hit counter after random run");
      csr_read(cache_pkg::CSR_MISSES, model_misses, "miss counter after random run");

      for (int i = 0; i < LINES; i++) begin
         if (mirror_valid[i]) begin
            cached.push_back({1'b0, mirror_tag[i], INDEX_W'(i), {OFF_W{1'b0}}});
         end
      end
      invalidate_cache();
      csr_read(cache_pkg::CSR_HITS, 0, "hit counter after invalidate");
      csr_read(cache_pkg::CSR_MISSES, 0, "miss counter after invalidate");
      foreach (cached[i]) begin
         data_access(cached[i], '0, '0, acc);
      end
      drain();
      idle_cycles(1);
      csr_read(cache_pkg::CSR_HITS, 0, "hit counter after re-read");
      csr_read(cache_pkg::CSR_MISSES, cached.size(), "miss counter after re-read");
      drain();

      $display("Simulation PASSED");
      $finish;
   end

endmodule

/* all.f */
design/cache_pkg.sv
design/cache_front_end.sv
design/cache_memory.sv
design/cache_back_end.sv
design/cache_ctrl.sv
design/cache_top.sv
bench/mem_model.sv
bench/cache_tb.sv

/* Bender.yml */
package:
  name: cache

sources:
  - design/cache_pkg.sv
  - design/cache_front_end.sv
  - design/cache_memory.sv
  - design/cache_back_end.sv
  - design/cache_ctrl.sv
  - design/cache_top.sv
  - target: test
    files:
      - bench/mem_model.sv
      - bench/cache_tb.sv
